//--- vlog.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/mc_ctrl_pkg.sv
verilog/ir_decoder.sv
verilog/branch_resolver.sv
verilog/step_counter.sv
verilog/control_sequencer.sv
verilog/control_word_table.sv
verilog/control_matrix.sv
testbench/control_matrix_chk.sv
testbench/tb_scoreboard.sv
testbench/tb_control_matrix.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_control_matrix
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_control_matrix.sv
`include "mc_config.svh"

module tb_control_matrix;

    localparam int NUM_INSTR        = 200;
    localparam int CLK_PERIOD       = 10;
    localparam int RESET_CYCLES     = 4;
    localparam int MAX_INSTR_CYCLES = 12;
    localparam int TIMEOUT          =
        (NUM_INSTR * MAX_INSTR_CYCLES + RESET_CYCLES + `MC_VEC_STEPS) * CLK_PERIOD;

    logic                    clk_i;
    logic                    resetComplete;
    rv_isa_pkg::instr_u      ir_i;
    rv_isa_pkg::flags_t      flags_i;
    logic                    mem_busy_i;
    mc_ctrl_pkg::ctrl_word_t ctrl_o;
    int                      test_count;
    int                      error_count;
    logic [31:0]             rng_state;
    logic [6:0]              opcode_tab [8];

    control_matrix uut (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .ir_i          (ir_i),
        .flags_i       (flags_i),
        .mem_busy_i    (mem_busy_i),
        .ctrl_o        (ctrl_o)
    );

    tb_scoreboard u_scoreboard (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .ir_i          (ir_i),
        .flags_i       (flags_i),
        .mem_busy_i    (mem_busy_i),
        .ctrl_i        (ctrl_o),
        .test_count_o  (test_count),
        .error_count_o (error_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Hang guard, worst case per instruction well under the limit
    initial begin
        #(TIMEOUT);
        $display("ERROR: watchdog expired after %0d time units, DUT stopped progressing",
                 TIMEOUT);
        $display("FAIL: see errors above");
        $finish;
    end

    // ------------------------------------------------------------
    // Stimulus, one word per fetch, held through execute
    // ------------------------------------------------------------
    initial begin
        logic [31:0] r;
        int          busy_left;
        // Seven supported opcodes plus auipc as the unknown code
        opcode_tab[0] = 7'b0000011;
        opcode_tab[1] = 7'b0100011;
        opcode_tab[2] = 7'b0110011;
        opcode_tab[3] = 7'b0010011;
        opcode_tab[4] = 7'b1100011;
        opcode_tab[5] = 7'b1101111;
        opcode_tab[6] = 7'b0110111;
        opcode_tab[7] = 7'b0010111;
        rng_state     = 32'd84970;
        resetComplete = 1'b1;
        ir_i          = '0;
        flags_i       = '0;
        mem_busy_i    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        resetComplete = 1'b0;

        for (int k = 0; k < NUM_INSTR; k++) begin
            while (uut.phase != mc_ctrl_pkg::PH_FETCH) begin
                @(posedge clk_i);
                #1;
            end
            rng_state  = xorshift32(rng_state);
            r          = rng_state;
            ir_i       = {r[31:7], opcode_tab[r[2:0]]};
            rng_state  = xorshift32(rng_state);
            flags_i    = rng_state[3:0];
            // 0 to 3 stall cycles at the start of fetch
            busy_left  = int'(rng_state[5:4]);
            mem_busy_i = (busy_left != 0);
            while (busy_left > 0) begin
                @(posedge clk_i);
                #1;
                busy_left--;
                mem_busy_i = (busy_left != 0);
            end
            while (uut.phase == mc_ctrl_pkg::PH_FETCH) begin
                @(posedge clk_i);
                #1;
            end
        end

        // One more fetch closes the last window
        while (uut.phase != mc_ctrl_pkg::PH_FETCH) begin
            @(posedge clk_i);
            #1;
        end
        repeat (3) @(posedge clk_i);

        if (error_count == 0 && test_count == NUM_INSTR + 1) begin
            $display("tests run %0d, errors %0d", test_count, error_count);
            $display("PASS: all tests");
        end
        else begin
            if (test_count != NUM_INSTR + 1) begin
                $display("ERROR: only %0d of %0d tests completed", test_count, NUM_INSTR + 1);
            end
            $display("tests run %0d, errors %0d", test_count, error_count);
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- testbench/tb_scoreboard.sv
`include "mc_config.svh"

module tb_scoreboard (
    input  logic                    clk_i,
    input  logic                    resetComplete,
    input  logic [31:0]             ir_i,
    input  logic [3:0]              flags_i,
    input  logic                    mem_busy_i,
    input  mc_ctrl_pkg::ctrl_word_t ctrl_i,
    output int                      test_count_o,
    output int                      error_count_o
);

    // Expected execute behavior of one instruction
    typedef struct packed {
        logic [3:0] exec_len;
        logic [3:0] rg_wr;
        logic [3:0] mem_wr;
        logic [3:0] mdr_ld;
        logic [3:0] pc_ld;
        logic       is_alu;
        logic [5:0] alu_op;
    } expect_t;

    // Counts collected over one execute window
    typedef struct packed {
        logic [3:0] exec_len;
        logic [3:0] rg_wr;
        logic [3:0] mem_wr;
        logic [3:0] mdr_ld;
        logic [3:0] pc_ld;
    } seen_t;

    int          rel_cnt;
    int          pos;
    int          test_err;
    int          instr_idx;
    logic        in_window;
    logic [31:0] held_ir;
    expect_t     cur_exp;
    seen_t       seen;
    logic [4:0]  vec_exp;
    logic [4:0]  vec_act;

    // ------------------------------------------------------------
    // Reference model from the class rules
    // ------------------------------------------------------------
    function automatic expect_t predict(input logic [31:0] ir, input logic [3:0] fl);
        expect_t    e;
        logic [2:0] f3;
        logic       taken;
        e  = '0;
        f3 = ir[14:12];
        case (f3)
            3'b000:  taken = fl[`MC_FLAG_Z];
            3'b001:  taken = !fl[`MC_FLAG_Z];
            3'b100:  taken = fl[`MC_FLAG_N] ^ fl[`MC_FLAG_V];
            3'b101:  taken = !(fl[`MC_FLAG_N] ^ fl[`MC_FLAG_V]);
            3'b110:  taken = fl[`MC_FLAG_C];
            3'b111:  taken = !fl[`MC_FLAG_C];
            default: taken = 1'b0;
        endcase
        case (ir[6:0])
            // load
            7'b0000011: begin
                e.exec_len = 4'd4;
                e.mdr_ld   = 4'd1;
                e.rg_wr    = 4'd1;
            end
            // store
            7'b0100011: begin
                e.exec_len = 4'd4;
                e.mem_wr   = 4'd1;
            end
            // R-type, qualifier from funct7 top bits
            7'b0110011: begin
                e.exec_len = 4'd2;
                e.rg_wr    = 4'd1;
                e.is_alu   = 1'b1;
                e.alu_op   = {f3, ir[31:29]};
            end
            // I-type, qualifier only on shifts
            7'b0010011: begin
                e.exec_len = 4'd2;
                e.rg_wr    = 4'd1;
                e.is_alu   = 1'b1;
                e.alu_op   = (f3 == 3'b001 || f3 == 3'b101) ? {f3, ir[31:29]} : {f3, 3'b000};
            end
            // branch, one extra cycle when taken
            7'b1100011: begin
                e.exec_len = taken ? 4'd3 : 4'd2;
                e.pc_ld    = {3'b000, taken};
            end
            7'b1101111: begin
                e.exec_len = 4'd3;
                e.pc_ld    = 4'd1;
                e.rg_wr    = 4'd1;
            end
            7'b0110111: begin
                e.exec_len = 4'd2;
                e.rg_wr    = 4'd1;
            end
            default: begin
                e.exec_len = 4'd1;
            end
        endcase
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("FAILED %s expected %0d actual %0d", name, exp_v, act_v);
            error_count_o++;
            test_err++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        error_count_o++;
        test_err++;
    endtask

    task automatic finish_test(input string name);
        if (test_err == 0) begin
            $display("test %s: ok", name);
        end
        else begin
            $display("test %s: %0d errors", name, test_err);
        end
        test_count_o++;
        test_err = 0;
    endtask

    // Close one instruction's execute window
    task automatic finish_instruction();
        string tag;
        tag = $sformatf("instr_%0d", instr_idx);
        compare_value({tag, " exec_len"}, 32'(cur_exp.exec_len), 32'(seen.exec_len));
        compare_value({tag, " rg_wr"}, 32'(cur_exp.rg_wr), 32'(seen.rg_wr));
        compare_value({tag, " mem_wr"}, 32'(cur_exp.mem_wr), 32'(seen.mem_wr));
        compare_value({tag, " mdr_ld"}, 32'(cur_exp.mdr_ld), 32'(seen.mdr_ld));
        compare_value({tag, " pc_ld"}, 32'(cur_exp.pc_ld), 32'(seen.pc_ld));
        finish_test($sformatf("%s opcode %b", tag, held_ir[6:0]));
        instr_idx++;
    endtask

    initial begin
        test_count_o  = 0;
        error_count_o = 0;
        test_err      = 0;
        instr_idx     = 0;
        in_window     = 1'b0;
        rel_cnt       = 0;
        pos           = 0;
        seen          = '0;
    end

    // ------------------------------------------------------------
    // Compare on the falling edge, inputs and outputs settled
    // ------------------------------------------------------------
    always @(negedge clk_i) begin
        if (resetComplete) begin
            rel_cnt   = 0;
            in_window = 1'b0;
        end
        else begin
            if (ctrl_i.ir_ld && mem_busy_i) begin
                report_problem("ir_ld raised while memory was busy");
            end
            if (ctrl_i.ir_ld != ctrl_i.pcp_ld) begin
                report_problem("ir_ld and pcp_ld did not pulse together");
            end
            if (ctrl_i.mem_rd && ctrl_i.mem_wr) begin
                report_problem("memory read and write requested in the same cycle");
            end

            if (rel_cnt < `MC_VEC_STEPS) begin
                // {pc_ld, mem_rd, rst_src, pc_src}
                case (rel_cnt)
                    0:       vec_exp = 5'b1_0_1_01;
                    2:       vec_exp = 5'b1_0_1_10;
                    default: vec_exp = 5'b0_1_1_00;
                endcase
                vec_act = {ctrl_i.pc_ld, ctrl_i.mem_rd, ctrl_i.rst_src, 2'(ctrl_i.pc_src)};
                compare_value($sformatf("reset_vector step %0d", rel_cnt),
                              32'(vec_exp), 32'(vec_act));
            end
            else begin
                if (rel_cnt == `MC_VEC_STEPS) begin
                    // First fetch cycle
                    compare_value("reset_vector fetch rst_src", 32'd0, 32'(ctrl_i.rst_src));
                    compare_value("reset_vector fetch ir_ld", 32'(!mem_busy_i),
                                  32'(ctrl_i.ir_ld));
                    finish_test("reset_vector");
                end

                if (ctrl_i.ir_ld) begin
                    if (in_window) begin
                        finish_instruction();
                    end
                    held_ir   = ir_i;
                    cur_exp   = predict(ir_i, flags_i);
                    in_window = 1'b1;
                    pos       = 0;
                    seen      = '0;
                end
                else if (mem_busy_i) begin
                    // Stall cycle, all strobes quiet
                    if ({ctrl_i.pc_ld, ctrl_i.flags_ld, ctrl_i.alu_ld, ctrl_i.mdr_ld,
                         ctrl_i.rg_wr, ctrl_i.mem_rd, ctrl_i.mem_wr} != 7'd0) begin
                        report_problem("strobe active during fetch back-pressure");
                    end
                end
                else if (in_window) begin
                    pos++;
                    if (pos == 1) begin
                        // Decode: ALU latch plus PC increment
                        compare_value($sformatf("instr_%0d decode", instr_idx), 32'd3,
                                      32'({ctrl_i.alu_ld, ctrl_i.pc_ld}));
                        compare_value($sformatf("instr_%0d decode pc_src", instr_idx), 32'd0,
                                      32'(ctrl_i.pc_src));
                    end
                    else begin
                        seen.exec_len = seen.exec_len + 4'd1;
                        seen.rg_wr    = seen.rg_wr + {3'b000, ctrl_i.rg_wr};
                        seen.mem_wr   = seen.mem_wr + {3'b000, ctrl_i.mem_wr};
                        seen.mdr_ld   = seen.mdr_ld + {3'b000, ctrl_i.mdr_ld};
                        seen.pc_ld    = seen.pc_ld + {3'b000, ctrl_i.pc_ld};
                        if (seen.exec_len == 4'd1 && cur_exp.is_alu) begin
                            compare_value($sformatf("instr_%0d alu_op", instr_idx),
                                          32'(cur_exp.alu_op), 32'(ctrl_i.alu_op));
                        end
                    end
                end
            end
            rel_cnt++;
        end
    end

endmodule

//--- testbench/control_matrix_chk.sv
module control_matrix_chk (
    input logic                    clk_i,
    input logic                    resetComplete,
    input logic                    mem_busy_i,
    input mc_ctrl_pkg::ctrl_word_t ctrl_i
);

    // Memory port is read or write, never both
    mem_exclusive: assert property (@(posedge clk_i) disable iff (resetComplete)
        !(ctrl_i.mem_rd && ctrl_i.mem_wr))
        else $error("mem_rd and mem_wr high in the same cycle");

    // IR must not load while memory is stalling
    ir_not_busy: assert property (@(posedge clk_i) disable iff (resetComplete)
        !(ctrl_i.ir_ld && mem_busy_i))
        else $error("ir_ld high while memory busy");

endmodule

// Watches the control word against the memory busy input
bind control_matrix control_matrix_chk u_chk (
    .clk_i         (clk_i),
    .resetComplete (resetComplete),
    .mem_busy_i    (mem_busy_i),
    .ctrl_i        (ctrl_o)
);

//--- verilog/control_matrix.sv
`include "mc_config.svh"

module control_matrix (
    input  logic                    clk_i,
    input  logic                    resetComplete,
    input  rv_isa_pkg::instr_u      ir_i,
    input  rv_isa_pkg::flags_t      flags_i,
    input  logic                    mem_busy_i,
    output mc_ctrl_pkg::ctrl_word_t ctrl_o
);

    mc_ctrl_pkg::iclass_e  iclass;
    mc_ctrl_pkg::iclass_e  iclass_q;
    mc_ctrl_pkg::phase_e   phase;
    logic [5:0]            alu_op;
    logic [2:0]            funct3;
    logic                  take_branch;
    logic [`MC_STEP_W-1:0] step;
    logic                  last;

    // ------------------------------------------------------------
    // Instruction side
    // ------------------------------------------------------------
    ir_decoder u_decoder (
        .ir_i     (ir_i),
        .iclass_o (iclass),
        .alu_op_o (alu_op),
        .funct3_o (funct3)
    );

    branch_resolver u_branch (
        .flags_i  (flags_i),
        .funct3_i (funct3),
        .take_o   (take_branch)
    );

    // ------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------
    control_sequencer u_sequencer (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .last_i        (last),
        .iclass_i      (iclass),
        .phase_o       (phase),
        .iclass_o      (iclass_q)
    );

    step_counter u_step (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .clear_i       (last),
        .step_o        (step)
    );

    // Control word and end-of-phase decision
    control_word_table u_table (
        .phase_i    (phase),
        .iclass_i   (iclass_q),
        .step_i     (step),
        .mem_busy_i (mem_busy_i),
        .take_i     (take_branch),
        .alu_op_i   (alu_op),
        .ctrl_o     (ctrl_o),
        .last_o     (last)
    );

endmodule

//--- verilog/control_word_table.sv
`include "mc_config.svh"

module control_word_table (
    input  mc_ctrl_pkg::phase_e     phase_i,
    input  mc_ctrl_pkg::iclass_e    iclass_i,
    input  logic [`MC_STEP_W-1:0]   step_i,
    input  logic                    mem_busy_i,
    input  logic                    take_i,
    input  logic [5:0]              alu_op_i,
    output mc_ctrl_pkg::ctrl_word_t ctrl_o,
    output logic                    last_o
);

    int step_n;

    assign step_n = int'(step_i);

    always_comb begin
        // Everything inactive, PC + 4 on the ALU
        ctrl_o        = '0;
        ctrl_o.pc_src = mc_ctrl_pkg::PC_ALU;
        ctrl_o.a_src  = mc_ctrl_pkg::A_PC;
        ctrl_o.b_src  = mc_ctrl_pkg::B_FOUR;
        ctrl_o.wd_src = mc_ctrl_pkg::WD_IMM;
        ctrl_o.alu_op = mc_ctrl_pkg::ALU_ADD;
        last_o        = 1'b0;

        case (phase_i)
            // ------------------------------------------------------------
            // Reset vector: PC from constant, then from memory
            // ------------------------------------------------------------
            mc_ctrl_pkg::PH_VECTOR: begin
                ctrl_o.rst_src = 1'b1;
                case (step_n)
                    0: begin
                        ctrl_o.pc_ld  = 1'b1;
                        ctrl_o.pc_src = mc_ctrl_pkg::PC_RST_VEC;
                    end
                    2: begin
                        ctrl_o.pc_ld  = 1'b1;
                        ctrl_o.pc_src = mc_ctrl_pkg::PC_RST_MEM;
                    end
                    default: begin
                        ctrl_o.mem_rd = 1'b1;
                    end
                endcase
                last_o = (step_n == `MC_VEC_STEPS - 1);
            end

            // Wait out busy, then IR and PC-prior together
            mc_ctrl_pkg::PH_FETCH: begin
                if (!mem_busy_i) begin
                    ctrl_o.ir_ld  = 1'b1;
                    ctrl_o.pcp_ld = 1'b1;
                    last_o        = 1'b1;
                end
            end

            // PC increment rides along with decode
            mc_ctrl_pkg::PH_DECODE: begin
                ctrl_o.alu_ld = 1'b1;
                ctrl_o.pc_ld  = 1'b1;
                last_o        = 1'b1;
            end

            // ------------------------------------------------------------
            // Execute, per class
            // ------------------------------------------------------------
            default: begin
                case (iclass_i)
                    mc_ctrl_pkg::IC_LOAD, mc_ctrl_pkg::IC_STORE: begin
                        // Address rs1 + imm into ALUOut
                        ctrl_o.a_src    = mc_ctrl_pkg::A_RSA;
                        ctrl_o.b_src    = mc_ctrl_pkg::B_IMM;
                        ctrl_o.addr_src = (step_n != 3);
                        ctrl_o.alu_ld   = (step_n == 0);
                        // Store reads first so memory can merge bytes
                        ctrl_o.mem_rd   = (step_n != 0) &&
                                          !(iclass_i == mc_ctrl_pkg::IC_STORE && step_n == 2);
                        ctrl_o.mem_wr   = (iclass_i == mc_ctrl_pkg::IC_STORE) && (step_n == 2);
                        ctrl_o.mdr_ld   = (iclass_i == mc_ctrl_pkg::IC_LOAD) && (step_n == 2);
                        ctrl_o.rg_wr    = (iclass_i == mc_ctrl_pkg::IC_LOAD) && (step_n == 3);
                        ctrl_o.wd_src   = mc_ctrl_pkg::WD_MDR;
                        last_o          = (step_n == 3);
                    end
                    mc_ctrl_pkg::IC_ALU_REG, mc_ctrl_pkg::IC_ALU_IMM: begin
                        if (step_n == 0) begin
                            ctrl_o.alu_ld   = 1'b1;
                            ctrl_o.a_src    = mc_ctrl_pkg::A_RSA;
                            ctrl_o.alu_op   = alu_op_i;
                            // Immediate form also updates flags
                            ctrl_o.flags_ld = (iclass_i == mc_ctrl_pkg::IC_ALU_IMM);
                            ctrl_o.b_src    = (iclass_i == mc_ctrl_pkg::IC_ALU_REG) ?
                                              mc_ctrl_pkg::B_RSB : mc_ctrl_pkg::B_IMM;
                        end
                        else begin
                            // Write back, start next fetch read
                            ctrl_o.wd_src = mc_ctrl_pkg::WD_ALUOUT;
                            ctrl_o.rg_wr  = 1'b1;
                            ctrl_o.mem_rd = 1'b1;
                            last_o        = 1'b1;
                        end
                    end
                    mc_ctrl_pkg::IC_BRANCH: begin
                        case (step_n)
                            0: begin
                                // Compare rs1 - rs2 into flags
                                ctrl_o.a_src    = mc_ctrl_pkg::A_RSA;
                                ctrl_o.b_src    = mc_ctrl_pkg::B_RSB;
                                ctrl_o.flags_ld = 1'b1;
                                ctrl_o.alu_op   = mc_ctrl_pkg::ALU_SUB;
                            end
                            1: begin
                                // Target is PC-prior + imm
                                ctrl_o.alu_ld = 1'b1;
                                ctrl_o.a_src  = mc_ctrl_pkg::A_PRIOR;
                                ctrl_o.b_src  = mc_ctrl_pkg::B_IMM;
                                ctrl_o.pc_ld  = take_i;
                                // Not taken finishes here
                                ctrl_o.mem_rd = !take_i;
                                last_o        = !take_i;
                            end
                            default: begin
                                ctrl_o.mem_rd = 1'b1;
                                last_o        = 1'b1;
                            end
                        endcase
                    end
                    mc_ctrl_pkg::IC_JAL: begin
                        ctrl_o.a_src = mc_ctrl_pkg::A_PRIOR;
                        case (step_n)
                            0: begin
                                // Jump target PC-prior + imm
                                ctrl_o.b_src = mc_ctrl_pkg::B_IMM;
                                ctrl_o.pc_ld = 1'b1;
                            end
                            1: begin
                                // Link value PC-prior + 4
                                ctrl_o.rg_wr = 1'b1;
                            end
                            default: begin
                                ctrl_o.mem_rd = 1'b1;
                                last_o        = 1'b1;
                            end
                        endcase
                    end
                    mc_ctrl_pkg::IC_LUI: begin
                        if (step_n == 0) begin
                            // rd = 0 + imm
                            ctrl_o.a_src = mc_ctrl_pkg::A_ZERO;
                            ctrl_o.b_src = mc_ctrl_pkg::B_IMM;
                            ctrl_o.rg_wr = 1'b1;
                        end
                        else begin
                            ctrl_o.mem_rd = 1'b1;
                            last_o        = 1'b1;
                        end
                    end
                    default: begin
                        // Unknown opcode, just re-read for the next fetch
                        ctrl_o.mem_rd = 1'b1;
                        last_o        = 1'b1;
                    end
                endcase
            end
        endcase
    end

endmodule

//--- verilog/control_sequencer.sv
module control_sequencer (
    input  logic                 clk_i,
    input  logic                 resetComplete,
    input  logic                 last_i,
    input  mc_ctrl_pkg::iclass_e iclass_i,
    output mc_ctrl_pkg::phase_e  phase_o,
    output mc_ctrl_pkg::iclass_e iclass_o
);

    // ------------------------------------------------------------
    // Phase FSM, advances only on the last step
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            phase_o  <= mc_ctrl_pkg::PH_VECTOR;
            iclass_o <= mc_ctrl_pkg::IC_UNKNOWN;
        end
        else if (last_i) begin
            case (phase_o)
                mc_ctrl_pkg::PH_VECTOR: begin
                    phase_o <= mc_ctrl_pkg::PH_FETCH;
                end
                mc_ctrl_pkg::PH_FETCH: begin
                    phase_o <= mc_ctrl_pkg::PH_DECODE;
                    // Class of the word being loaded into IR
                    iclass_o <= iclass_i;
                end
                mc_ctrl_pkg::PH_DECODE: begin
                    phase_o <= mc_ctrl_pkg::PH_EXEC;
                end
                default: begin
                    // Execute done, back for the next word
                    phase_o <= mc_ctrl_pkg::PH_FETCH;
                end
            endcase
        end
    end

endmodule

//--- verilog/step_counter.sv
`include "mc_config.svh"

module step_counter (
    input  logic                  clk_i,
    input  logic                  resetComplete,
    input  logic                  clear_i,
    output logic [`MC_STEP_W-1:0] step_o
);

    // Step within current phase
    // Restarts on the last step of every phase
    always_ff @(posedge clk_i) begin
        if (resetComplete || clear_i) begin
            step_o <= '0;
        end
        else begin
            step_o <= step_o + 1'b1;
        end
    end

endmodule

//--- verilog/branch_resolver.sv
`include "mc_config.svh"

module branch_resolver (
    input  rv_isa_pkg::flags_t flags_i,
    input  logic [2:0]         funct3_i,
    output logic               take_o
);

    logic z;
    logic c;
    logic n;
    logic v;

    assign z = flags_i[`MC_FLAG_Z];
    assign c = flags_i[`MC_FLAG_C];
    assign n = flags_i[`MC_FLAG_N];
    assign v = flags_i[`MC_FLAG_V];

    // Flags come from rs1 - rs2
    always_comb begin
        case (funct3_i)
            rv_isa_pkg::BR_EQ:  take_o = z;
            rv_isa_pkg::BR_NE:  take_o = ~z;
            // Signed compare via N xor V
            rv_isa_pkg::BR_LT:  take_o = n ^ v;
            rv_isa_pkg::BR_GE:  take_o = ~(n ^ v);
            // Unsigned, borrow shows up as C
            rv_isa_pkg::BR_LTU: take_o = c;
            rv_isa_pkg::BR_GEU: take_o = ~c;
            default:            take_o = 1'b0;
        endcase
    end

endmodule

//--- verilog/ir_decoder.sv
module ir_decoder (
    input  rv_isa_pkg::instr_u   ir_i,
    output mc_ctrl_pkg::iclass_e iclass_o,
    output logic [5:0]           alu_op_o,
    output logic [2:0]           funct3_o
);

    // ALU operation qualifier, low 3 bits of alu_op
    logic [2:0] qual;
    logic       is_shift;

    assign funct3_o = ir_i.r.funct3;

    // slli is 001, srli and srai share 101
    assign is_shift = (funct3_o == 3'b001) || (funct3_o == 3'b101);

    // Opcode to class, anything else unknown
    always_comb begin
        case (ir_i.r.opcode)
            rv_isa_pkg::OP_LOAD:   iclass_o = mc_ctrl_pkg::IC_LOAD;
            rv_isa_pkg::OP_STORE:  iclass_o = mc_ctrl_pkg::IC_STORE;
            rv_isa_pkg::OP_REG:    iclass_o = mc_ctrl_pkg::IC_ALU_REG;
            rv_isa_pkg::OP_IMM:    iclass_o = mc_ctrl_pkg::IC_ALU_IMM;
            rv_isa_pkg::OP_BRANCH: iclass_o = mc_ctrl_pkg::IC_BRANCH;
            rv_isa_pkg::OP_JAL:    iclass_o = mc_ctrl_pkg::IC_JAL;
            rv_isa_pkg::OP_LUI:    iclass_o = mc_ctrl_pkg::IC_LUI;
            default:               iclass_o = mc_ctrl_pkg::IC_UNKNOWN;
        endcase
    end

    // R-type takes funct7 upper bits
    // I-type uses the immediate top bits only on shifts
    always_comb begin
        qual = 3'b000;
        if (iclass_o == mc_ctrl_pkg::IC_ALU_REG) begin
            qual = ir_i.r.funct7[6:4];
        end
        else if (iclass_o == mc_ctrl_pkg::IC_ALU_IMM && is_shift) begin
            qual = ir_i.i.imm[11:9];
        end
    end

    assign alu_op_o = {funct3_o, qual};

endmodule

//--- verilog/mc_ctrl_pkg.sv
package mc_ctrl_pkg;

    // Top-level sequencing phase
    typedef enum logic [1:0] {
        PH_VECTOR = 2'd0,
        PH_FETCH  = 2'd1,
        PH_DECODE = 2'd2,
        PH_EXEC   = 2'd3
    } phase_e;

    // Instruction class, picks the execute sequence
    typedef enum logic [2:0] {
        IC_LOAD    = 3'd0,
        IC_STORE   = 3'd1,
        IC_ALU_REG = 3'd2,
        IC_ALU_IMM = 3'd3,
        IC_BRANCH  = 3'd4,
        IC_JAL     = 3'd5,
        IC_LUI     = 3'd6,
        IC_UNKNOWN = 3'd7
    } iclass_e;

    // ------------------------------------------------------------
    // Datapath mux selects
    // ------------------------------------------------------------
    // PC input: ALU direct, reset constant, reset address from memory
    typedef enum logic [1:0] {
        PC_ALU     = 2'd0,
        PC_RST_VEC = 2'd1,
        PC_RST_MEM = 2'd2
    } pc_src_e;

    typedef enum logic [1:0] {
        A_PC    = 2'd0,
        A_RSA   = 2'd1,
        A_PRIOR = 2'd2,
        A_ZERO  = 2'd3
    } a_src_e;

    typedef enum logic [1:0] {
        B_FOUR = 2'd0,
        B_RSB  = 2'd1,
        B_IMM  = 2'd2
    } b_src_e;

    // Register-file write data
    typedef enum logic [1:0] {
        WD_IMM    = 2'd0,
        WD_MDR    = 2'd1,
        WD_ALUOUT = 2'd2
    } wd_src_e;

    // ALU codes are {funct3, qualifier}
    localparam logic [5:0] ALU_ADD = 6'b000_000;
    localparam logic [5:0] ALU_SUB = 6'b000_010;

    // One cycle's worth of control, strobes active high
    typedef struct packed {
        logic       ir_ld;
        logic       pc_ld;
        logic       pcp_ld;
        logic       flags_ld;
        logic       alu_ld;
        logic       mdr_ld;
        logic       rg_wr;
        logic       mem_rd;
        logic       mem_wr;
        logic       addr_src;
        logic       rst_src;
        pc_src_e    pc_src;
        a_src_e     a_src;
        b_src_e     b_src;
        wd_src_e    wd_src;
        logic [5:0] alu_op;
    } ctrl_word_t;

endpackage

//--- verilog/rv_isa_pkg.sv
`include "mc_config.svh"

package rv_isa_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_LUI    = 7'b0110111
    } opcode_e;

    // Branch conditions, carried in funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_funct3_e;

    // R-type field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_view_t;

    // I-type layout; lower part same as the R view
    // Top 3 immediate bits qualify shifts
    typedef struct packed {
        logic [11:0]          imm;
        logic [`MC_XLEN-13:0] low;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_u;

    // ALU flags, V in the top bit
    typedef struct packed {
        logic v;
        logic n;
        logic c;
        logic z;
    } flags_t;

endpackage

//--- verilog/mc_config.svh
`ifndef MC_CONFIG_SVH
`define MC_CONFIG_SVH

// ------------------------------------------------------------
// Datapath sizing
// ------------------------------------------------------------
// Instruction and data word width
`define MC_XLEN 32

// Step counter width, covers the longest execute sequence
`define MC_STEP_W 2

// Steps in the reset-vector sequence
`define MC_VEC_STEPS 4

// ------------------------------------------------------------
// Flag bit positions inside flags_t
// ------------------------------------------------------------
`define MC_FLAG_Z 0
`define MC_FLAG_C 1
`define MC_FLAG_N 2
`define MC_FLAG_V 3

`endif
